// ==== run.sh ====
#!/usr/bin/env bash
# build and run the io_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module io_tb --Mdir obj_dir -o io_tb_sim \
    && ./obj_dir/io_tb_sim \
    || { echo "simulation failed"; exit 1; }

// ==== sim/io_tb.sv ====
module io_tb;
    import io_pkg::*;
    import serial_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 4;
    localparam int CLK_PERIOD   = 10;
    localparam int N_OUT        = 6;
    localparam int N_BURST      = 10;
    localparam int TOTAL_BYTES  = N_OUT + N_BURST + 4 + 1;
    localparam longint WATCHDOG_TIME = longint'(TOTAL_BYTES) * 10 * CLKS_PER_BIT * CLK_PERIOD * 4;

    logic   clk;
    logic   rstn;
    logic   cmd_valid;
    io_op_t cmd_op;
    byte_t  cmd_byte;
    logic   busy;
    word_t  rdata;
    logic   rdata_valid;
    logic   rx;
    logic   tx;

    byte_t exp_tx[$];
    byte_t got_tx[$];
    word_t exp_words[$];

    io_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (
        .clk(clk), .rstn(rstn),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_byte(cmd_byte),
        .busy(busy), .rdata(rdata), .rdata_valid(rdata_valid),
        .rx(rx), .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // checking helpers and reference model
    // ==================================================

    task automatic fail_run(input string why);
        $display("error: %s", why);
        $display("Test failures found");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    // byte goes into the lane picked by the opcode
    function automatic word_t ref_word(input word_t prev, input io_op_t op, input byte_t b);
        int    lane;
        word_t mask;
        case (op)
            OP_IN_LL: lane = 0;
            OP_IN_LH: lane = 1;
            OP_IN_UL: lane = 2;
            OP_IN_UH: lane = 3;
            default:  return prev;
        endcase
        mask = word_t'(8'hff) << (8 * lane);
        return (prev & ~mask) | (word_t'(b) << (8 * lane));
    endfunction

    // ==================================================
    // serial driver and command issue
    // ==================================================

    task automatic send_frame(input byte_t b);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < BYTE_W; i++) begin
            rx = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    // starts on a falling edge and returns once busy drops
    task automatic issue_cmd(input io_op_t op, input byte_t b, output int busy_cycles);
        busy_cycles = 0;
        while (busy) @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_byte  = b;
        @(negedge clk);
        cmd_valid = 1'b0;
        while (busy) begin
            busy_cycles++;
            @(negedge clk);
        end
    endtask

    task automatic drain_tx();
        while (exp_tx.size() != 0) @(negedge clk);
    endtask

    // ==================================================
    // tx monitor and compare
    // ==================================================

    initial begin
        byte_t b;
        forever begin
            @(negedge clk);
            if (rstn && tx === 1'b0) begin
                // move to the middle of the start bit
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
                check_eq("tx start bit", 32'(tx), 32'h0);
                for (int i = 0; i < BYTE_W; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_eq("tx stop bit", 32'(tx), 32'h1);
                got_tx.push_back(b);
            end
        end
    end

    initial begin
        word_t exp_w;
        byte_t got_b;
        byte_t exp_b;
        forever begin
            @(negedge clk);
            if (rstn && rdata_valid) begin
                if (exp_words.size() == 0) begin
                    fail_run("rdata_valid pulsed with no in command pending");
                end else begin
                    exp_w = exp_words.pop_front();
                    check_eq("rdata", rdata, exp_w);
                end
            end
            if (got_tx.size() != 0) begin
                if (exp_tx.size() == 0) begin
                    fail_run("byte appeared on tx that was never sent");
                end else begin
                    got_b = got_tx.pop_front();
                    exp_b = exp_tx.pop_front();
                    check_eq("tx byte", 32'(got_b), 32'(exp_b));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        fail_run("watchdog expired, DUT stopped responding");
    end

    // ==================================================
    // stimulus
    // ==================================================

    initial begin
        int          cycles;
        int          max_busy;
        word_t       model_word;
        byte_t       b;
        byte_t       rx_bytes[4];

        cmd_valid  = 1'b0;
        cmd_op     = OP_IN_LL;
        cmd_byte   = '0;
        rx         = 1'b1;
        rstn       = 1'b0;
        model_word = '0;
        max_busy   = 0;
        void'($urandom(32'h5984));

        repeat (3) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // idle outputs after reset
        check_eq("busy", 32'(busy), 32'h0);
        check_eq("rdata_valid", 32'(rdata_valid), 32'h0);
        check_eq("tx", 32'(tx), 32'h1);
        check_eq("rdata", rdata, 32'h0);

        // single out commands
        for (int i = 0; i < N_OUT; i++) begin
            b = byte_t'($urandom());
            exp_tx.push_back(b);
            issue_cmd(OP_OUT, b, cycles);
        end
        drain_tx();

        // burst deeper than the FIFO stalls on credits
        for (int i = 0; i < N_BURST; i++) begin
            b = byte_t'($urandom());
            exp_tx.push_back(b);
            issue_cmd(OP_OUT, b, cycles);
            if (cycles > max_busy) begin
                max_busy = cycles;
            end
        end
        if (max_busy < 2) begin
            fail_run("busy never held for back-pressure during out burst");
        end
        drain_tx();

        // four bytes queued first and then one in per lane
        for (int k = 0; k < 4; k++) begin
            rx_bytes[k] = byte_t'($urandom());
            send_frame(rx_bytes[k]);
        end
        for (int k = 0; k < 4; k++) begin
            model_word = ref_word(model_word, io_op_t'(k), rx_bytes[k]);
            exp_words.push_back(model_word);
            issue_cmd(io_op_t'(k), '0, cycles);
        end

        // in with an idle line must hold busy
        b          = byte_t'($urandom());
        model_word = ref_word(model_word, OP_IN_UL, b);
        exp_words.push_back(model_word);
        fork
            issue_cmd(OP_IN_UL, '0, cycles);
            begin
                @(negedge clk);
                repeat (20) begin
                    check_eq("busy", 32'(busy), 32'h1);
                    check_eq("rdata_valid", 32'(rdata_valid), 32'h0);
                    @(negedge clk);
                end
                send_frame(b);
            end
        join

        @(negedge clk);
        if (exp_tx.size() != 0 || got_tx.size() != 0 || exp_words.size() != 0) begin
            fail_run("expected responses left unchecked at end of run");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== src.f ====
src/io_pkg.sv
src/serial_pkg.sv
src/byte_fifo.sv
src/uart_tx_core.sv
src/uart_rx_core.sv
src/io_sequencer.sv
src/io_top.sv
sim/io_tb.sv

// ==== src/byte_fifo.sv ====
module byte_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              push,
    input  serial_pkg::byte_t push_data,
    input  logic              pop,
    output logic              credit,
    output logic              valid,
    output serial_pkg::byte_t head_data
);
    import serial_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    byte_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign valid   = (count != '0);
    assign do_push = push && !full;
    assign do_pop  = pop && valid;

    // one credit back per entry leaving
    assign credit    = do_pop;
    assign head_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // producer credit counter must keep these from happening
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !full)
        else $error("byte_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        pop |-> valid)
        else $error("byte_fifo: pop while empty");

endmodule

// ==== src/io_pkg.sv ====
package io_pkg;

    // ==================================================
    // serial I/O instruction set
    // ==================================================

    typedef enum logic [2:0] {
        OP_IN_LL,
        OP_IN_LH,
        OP_IN_UL,
        OP_IN_UH,
        OP_OUT
    } io_op_t;

    // sequencer interlock states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_RX,
        SEQ_WAIT_TX
    } seq_state_t;

    // ==================================================
    // result word, four byte lanes
    // ==================================================

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

endpackage

// ==== src/io_sequencer.sv ====
module io_sequencer #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cmd_valid,
    input  io_pkg::io_op_t    cmd_op,
    input  serial_pkg::byte_t cmd_byte,
    input  logic              tx_credit,
    input  logic              rx_valid,
    input  serial_pkg::byte_t rx_data,
    output logic              busy,
    output io_pkg::word_t     rdata,
    output logic              rdata_valid,
    output logic              tx_push,
    output serial_pkg::byte_t tx_data,
    output logic              rx_pop
);
    import io_pkg::*;

    localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

    seq_state_t        state;
    io_op_t            op;
    logic [CRED_W-1:0] tx_credits;
    word_t             merged;

    assign busy    = (state != SEQ_IDLE);
    assign tx_push = (state == SEQ_WAIT_TX) && (tx_credits != '0);
    assign rx_pop  = (state == SEQ_WAIT_RX) && rx_valid;

    // only the addressed lane takes the new byte
    always_comb begin
        merged = rdata;
        case (op)
            OP_IN_LL: merged[7:0]   = rx_data;
            OP_IN_LH: merged[15:8]  = rx_data;
            OP_IN_UL: merged[23:16] = rx_data;
            OP_IN_UH: merged[31:24] = rx_data;
            default:  merged        = rdata;
        endcase
    end

    // ==================================================
    // interlock FSM
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= SEQ_IDLE;
            rdata       <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (cmd_valid) begin
                        op      <= cmd_op;
                        tx_data <= cmd_byte;
                        state   <= (cmd_op == OP_OUT) ? SEQ_WAIT_TX : SEQ_WAIT_RX;
                    end
                end
                SEQ_WAIT_TX: begin
                    if (tx_push) begin
                        state <= SEQ_IDLE;
                    end
                end
                SEQ_WAIT_RX: begin
                    if (rx_pop) begin
                        rdata       <= merged;
                        rdata_valid <= 1'b1;
                        state       <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // tx FIFO slots we may still fill
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_credits <= CRED_W'(FIFO_DEPTH);
        end else if (tx_credit && !tx_push) begin
            tx_credits <= tx_credits + CRED_W'(1);
        end else if (!tx_credit && tx_push) begin
            tx_credits <= tx_credits - CRED_W'(1);
        end
    end

    // FIFO must never return more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rstn)
        tx_credits <= CRED_W'(FIFO_DEPTH))
        else $error("io_sequencer: tx credits above FIFO depth");

endmodule

// ==== src/io_top.sv ====
module io_top #(
    parameter int CLKS_PER_BIT = 8,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cmd_valid,
    input  io_pkg::io_op_t    cmd_op,
    input  serial_pkg::byte_t cmd_byte,
    output logic              busy,
    output io_pkg::word_t     rdata,
    output logic              rdata_valid,
    input  logic              rx,
    output logic              tx
);
    import serial_pkg::*;

    // tx path, sequencer -> FIFO -> serializer
    logic  tx_push;
    byte_t tx_push_data;
    logic  tx_credit;
    logic  tx_valid;
    byte_t tx_head;
    logic  tx_pop;

    // rx path, deserializer -> FIFO -> sequencer
    logic  rx_push;
    byte_t rx_push_data;
    logic  rx_credit;
    logic  rx_valid;
    byte_t rx_head;
    logic  rx_pop;

    io_sequencer #(.FIFO_DEPTH(FIFO_DEPTH)) io_sequencer_i (
        .clk(clk), .rstn(rstn),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_byte(cmd_byte),
        .tx_credit(tx_credit), .rx_valid(rx_valid), .rx_data(rx_head),
        .busy(busy), .rdata(rdata), .rdata_valid(rdata_valid),
        .tx_push(tx_push), .tx_data(tx_push_data), .rx_pop(rx_pop)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
        .clk(clk), .rstn(rstn),
        .push(tx_push), .push_data(tx_push_data), .pop(tx_pop),
        .credit(tx_credit), .valid(tx_valid), .head_data(tx_head)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
        .clk(clk), .rstn(rstn),
        .push(rx_push), .push_data(rx_push_data), .pop(rx_pop),
        .credit(rx_credit), .valid(rx_valid), .head_data(rx_head)
    );

    uart_tx_core #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_core_i (
        .clk(clk), .rstn(rstn),
        .valid(tx_valid), .data(tx_head), .pop(tx_pop), .tx(tx)
    );

    uart_rx_core #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) uart_rx_core_i (
        .clk(clk), .rstn(rstn),
        .rx(rx), .credit(rx_credit), .push(rx_push), .data(rx_push_data)
    );

endmodule

// ==== src/serial_pkg.sv ====
package serial_pkg;

    // ==================================================
    // serial data
    // ==================================================

    localparam int BYTE_W = 8;

    typedef logic [BYTE_W-1:0] byte_t;

    // ==================================================
    // 8N1 framing
    // ==================================================

    // one state per frame section
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

// ==== src/uart_rx_core.sv ====
module uart_rx_core #(
    parameter int CLKS_PER_BIT = 8,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              rx,
    input  logic              credit,
    output logic              push,
    output serial_pkg::byte_t data
);
    import serial_pkg::*;

    localparam int CNT_W  = $clog2(CLKS_PER_BIT);
    localparam int IDX_W  = $clog2(BYTE_W);
    localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

    uart_state_t       state;
    logic              rx_s1;
    logic              rx_s2;
    logic              rx_prev;
    logic              start_edge;
    logic [CNT_W-1:0]  clk_cnt;
    logic [IDX_W-1:0]  bit_idx;
    byte_t             shift;
    logic              bit_end;
    logic              half_bit;
    logic [CRED_W-1:0] credits;

    // two flop synchronizer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_s1   <= 1'b1;
            rx_s2   <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_s1   <= rx;
            rx_s2   <= rx_s1;
            rx_prev <= rx_s2;
        end
    end

    assign start_edge = rx_prev && !rx_s2;
    assign bit_end    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign half_bit   = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            push    <= 1'b0;
        end else begin
            push    <= 1'b0;
            clk_cnt <= clk_cnt + CNT_W'(1);
            case (state)
                UART_IDLE: begin
                    clk_cnt <= '0;
                    if (start_edge) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    // mid start bit, realign to bit centres
                    if (half_bit) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s2 ? UART_IDLE : UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        shift   <= {rx_s2, shift[BYTE_W-1:1]};
                        bit_idx <= bit_idx + IDX_W'(1);
                        if (bit_idx == IDX_W'(BYTE_W - 1)) begin
                            state <= UART_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= UART_IDLE;
                        // bad stop bit or no room, byte dropped
                        if (rx_s2 && credits != '0) begin
                            push <= 1'b1;
                            data <= shift;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credits <= CRED_W'(FIFO_DEPTH);
        end else if (credit && !push) begin
            credits <= credits + CRED_W'(1);
        end else if (!credit && push) begin
            credits <= credits - CRED_W'(1);
        end
    end

endmodule

// ==== src/uart_tx_core.sv ====
module uart_tx_core #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              valid,
    input  serial_pkg::byte_t data,
    output logic              pop,
    output logic              tx
);
    import serial_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(BYTE_W);

    uart_state_t      state;
    logic [CNT_W-1:0] clk_cnt;
    logic [IDX_W-1:0] bit_idx;
    byte_t            shift;
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            pop     <= 1'b0;
            tx      <= 1'b1;
        end else begin
            pop <= 1'b0;
            if (state != UART_IDLE) begin
                clk_cnt <= bit_end ? '0 : clk_cnt + CNT_W'(1);
            end
            case (state)
                UART_IDLE: begin
                    // head is latched now, popped next cycle
                    if (valid) begin
                        shift   <= data;
                        pop     <= 1'b1;
                        tx      <= 1'b0;
                        clk_cnt <= '0;
                        state   <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        tx      <= shift[0];
                        bit_idx <= '0;
                        state   <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == IDX_W'(BYTE_W - 1)) begin
                            tx    <= 1'b1;
                            state <= UART_STOP;
                        end else begin
                            // lsb first
                            tx      <= shift[1];
                            shift   <= {1'b0, shift[BYTE_W-1:1]};
                            bit_idx <= bit_idx + IDX_W'(1);
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= UART_IDLE;
                    end
                end
            endcase
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rstn)
        (state == UART_IDLE) |-> tx)
        else $error("uart_tx_core: line low while idle");

endmodule
